//--- source/sb_pkg.sv
// Issue scoreboard shared types

package sb_pkg;

    // ============================
    // Basic types
    // ============================

    // Architectural register index
    // x0 is hardwired, never a hazard source
    typedef logic [4:0] reg_addr_t;

    // Cycle count, must hold the divider latency plus the bypass stage
    typedef logic [5:0] latency_t;

    // Functional unit selected by the dispatch stage
    typedef enum logic [1:0] {
        UNIT_NONE = 2'b00,  // bubble
        UNIT_ALU  = 2'b01,  // single cycle, CSR ops go here too
        UNIT_MUL  = 2'b10,  // pipelined multiplier
        UNIT_DIV  = 2'b11   // sequential divider
    } sb_unit_e;

    // ============================
    // Request and hazard bundles
    // ============================

    // Dispatch request, held until accepted
    typedef struct packed {
        sb_unit_e  unit;
        reg_addr_t src0;
        reg_addr_t src1;
        reg_addr_t dest;
    } sb_request_t;

    // Per tracker status
    typedef struct packed {
        logic raw;        // register match with an in-flight destination
        logic collision;  // same write-back cycle as an in-flight op
        logic busy;       // some op still executing
    } sb_hazard_t;

    // ============================
    // Latencies
    // ============================

    // ALU result is ready one cycle after execute
    localparam int ALU_LATENCY = 1;

    // Bypass stage sits between issue and execute
    localparam int BYPASS_CYCLES = 1;

    // Defaults for the top level parameters
    localparam int DEF_MUL_LATENCY = 5;
    localparam int DEF_DIV_LATENCY = 36;

endpackage : sb_pkg

//--- source/pipe_unit_tracker.sv
// Pipelined unit hazard tracker

`timescale 1ns/100ps

module pipe_unit_tracker #(
    parameter int LATENCY = sb_pkg::DEF_MUL_LATENCY
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                flush_i,
    input  logic                stall_i,
    input  logic                load_i,
    input  sb_pkg::sb_request_t req_i,
    input  sb_pkg::latency_t    req_latency_i,
    output sb_pkg::sb_hazard_t  hazard_o
);

    // One bit per pipeline slot
    typedef logic [LATENCY-1:0] slot_vec_t;

    // ============================
    // Slot pointer
    // ============================

    // One-hot, selects the slot the next accepted op lands in
    slot_vec_t slot_ptr;

    always_ff @(posedge clk_i) begin : slot_pointer
        if (!rst_n_i || flush_i) begin
            slot_ptr <= slot_vec_t'(1);
        end else if (load_i) begin
            // Rotate, last slot wraps back to slot 0
            if (slot_ptr[LATENCY-1]) begin
                slot_ptr <= slot_vec_t'(1);
            end else begin
                slot_ptr <= slot_ptr << 1;
            end
        end
    end : slot_pointer

    // ============================
    // Per slot state
    // ============================

    sb_pkg::latency_t  slot_cnt  [LATENCY];
    sb_pkg::reg_addr_t slot_dest [LATENCY];

    slot_vec_t slot_exec;
    slot_vec_t slot_raw;
    slot_vec_t slot_coll;

    for (genvar i = 0; i < LATENCY; i++) begin : g_slot

        // Remaining cycles until this slot writes back
        always_ff @(posedge clk_i) begin : slot_counter
            if (!rst_n_i || flush_i) begin
                slot_cnt[i] <= '0;
            end else if (!stall_i) begin
                if (load_i && slot_ptr[i]) begin
                    slot_cnt[i] <= sb_pkg::latency_t'(LATENCY);
                end else if (slot_cnt[i] != '0) begin
                    slot_cnt[i] <= slot_cnt[i] - 1'b1;
                end
            end
        end : slot_counter

        // Destination captured on accept
        // load_i is already low during a stall
        always_ff @(posedge clk_i) begin : slot_destination
            if (load_i && slot_ptr[i]) begin
                slot_dest[i] <= req_i.dest;
            end
        end : slot_destination

        // Last count means the result is on the bypass path already
        assign slot_exec[i] = (slot_cnt[i] > sb_pkg::latency_t'(1));

        // RAW on sources, WAW on the destination
        assign slot_raw[i] = slot_exec[i] && (slot_dest[i] != '0) &&
                             ((req_i.src0 == slot_dest[i]) ||
                              (req_i.src1 == slot_dest[i]) ||
                              (req_i.dest == slot_dest[i]));

        // Both results would hit the write port in the same cycle
        assign slot_coll[i] = slot_exec[i] && (req_latency_i == slot_cnt[i]);

    end : g_slot

    // ============================
    // Hazard summary
    // ============================

    assign hazard_o = '{
        raw:       |slot_raw,
        collision: |slot_coll,
        busy:      |slot_exec
    };

endmodule : pipe_unit_tracker

//--- source/seq_unit_tracker.sv
// Sequential unit hazard tracker

`timescale 1ns/100ps

module seq_unit_tracker #(
    parameter int LATENCY = sb_pkg::DEF_DIV_LATENCY
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                flush_i,
    input  logic                stall_i,
    input  logic                load_i,
    input  sb_pkg::sb_request_t req_i,
    input  sb_pkg::latency_t    req_latency_i,
    output sb_pkg::sb_hazard_t  hazard_o
);

    // ============================
    // Unit state
    // ============================

    // Only one op at a time in a non pipelined unit
    sb_pkg::latency_t  cnt;
    sb_pkg::reg_addr_t dest;
    logic              executing;

    // Cycles left until write-back, frozen by stall
    always_ff @(posedge clk_i) begin : latency_counter
        if (!rst_n_i || flush_i) begin
            cnt <= '0;
        end else if (!stall_i) begin
            if (load_i) begin
                cnt <= sb_pkg::latency_t'(LATENCY);
            end else if (cnt != '0) begin
                cnt <= cnt - 1'b1;
            end
        end
    end : latency_counter

    // Destination of the op in flight
    always_ff @(posedge clk_i) begin : destination
        if (load_i) begin
            dest <= req_i.dest;
        end
    end : destination

    assign executing = (cnt > sb_pkg::latency_t'(1));

    // ============================
    // Hazard summary
    // ============================

    // busy doubles as the structural hazard for a second DIV
    assign hazard_o.raw = executing && (dest != '0) &&
                          ((req_i.src0 == dest) ||
                           (req_i.src1 == dest) ||
                           (req_i.dest == dest));
    assign hazard_o.collision = executing && (req_latency_i == cnt);
    assign hazard_o.busy      = executing;

endmodule : seq_unit_tracker

//--- source/issue_control.sv
// Issue decision logic

`timescale 1ns/100ps

module issue_control #(
    parameter int MUL_LATENCY = sb_pkg::DEF_MUL_LATENCY,
    parameter int DIV_LATENCY = sb_pkg::DEF_DIV_LATENCY
) (
    input  logic                stall_i,
    input  sb_pkg::sb_request_t req_i,
    input  sb_pkg::sb_hazard_t  mul_hazard_i,
    input  sb_pkg::sb_hazard_t  div_hazard_i,
    output sb_pkg::latency_t    req_latency_o,
    output logic                mul_load_o,
    output logic                div_load_o,
    output logic                issue_o,
    output logic                pipeline_empty_o
);

    // ============================
    // Requested latency
    // ============================

    // Every unit sees one extra cycle for the bypass stage
    localparam sb_pkg::latency_t ALU_REQ_LAT =
        sb_pkg::latency_t'(sb_pkg::ALU_LATENCY + sb_pkg::BYPASS_CYCLES);
    localparam sb_pkg::latency_t MUL_REQ_LAT =
        sb_pkg::latency_t'(MUL_LATENCY + sb_pkg::BYPASS_CYCLES);
    localparam sb_pkg::latency_t DIV_REQ_LAT =
        sb_pkg::latency_t'(DIV_LATENCY + sb_pkg::BYPASS_CYCLES);

    always_comb begin : latency_lookup
        case (req_i.unit)
            sb_pkg::UNIT_ALU: req_latency_o = ALU_REQ_LAT;
            sb_pkg::UNIT_MUL: req_latency_o = MUL_REQ_LAT;
            sb_pkg::UNIT_DIV: req_latency_o = DIV_REQ_LAT;
            // Bubble, all ones never matches a live counter
            default:          req_latency_o = '1;
        endcase
    end : latency_lookup

    // ============================
    // Issue
    // ============================

    logic raw_hazard;
    logic collision;
    logic structural;

    assign raw_hazard = mul_hazard_i.raw | div_hazard_i.raw;
    assign collision  = mul_hazard_i.collision | div_hazard_i.collision;
    // Divider takes one op at a time
    assign structural = (req_i.unit == sb_pkg::UNIT_DIV) & div_hazard_i.busy;

    assign issue_o = !(raw_hazard | collision | structural);

    // Request accepted at the next edge
    assign mul_load_o = (req_i.unit == sb_pkg::UNIT_MUL) & issue_o & !stall_i;
    assign div_load_o = (req_i.unit == sb_pkg::UNIT_DIV) & issue_o & !stall_i;

    assign pipeline_empty_o = !(mul_hazard_i.busy | div_hazard_i.busy);

endmodule : issue_control

//--- source/scoreboard_top.sv
// Issue scoreboard top level

`timescale 1ns/100ps

module scoreboard_top #(
    parameter int MUL_LATENCY = sb_pkg::DEF_MUL_LATENCY,
    parameter int DIV_LATENCY = sb_pkg::DEF_DIV_LATENCY
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                flush_i,
    input  logic                stall_i,
    input  sb_pkg::sb_request_t req_i,
    output logic                issue_o,
    output logic                pipeline_empty_o
);

    // ============================
    // Internal wiring
    // ============================

    sb_pkg::sb_hazard_t mul_hazard;
    sb_pkg::sb_hazard_t div_hazard;
    sb_pkg::latency_t   req_latency;
    logic               mul_load;
    logic               div_load;

    // Multiplier, one slot per pipeline stage
    pipe_unit_tracker #(
        .LATENCY        (MUL_LATENCY)
    ) u_mul (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .stall_i        (stall_i),
        .load_i         (mul_load),
        .req_i          (req_i),
        .req_latency_i  (req_latency),
        .hazard_o       (mul_hazard)
    );

    // Divider, single op in flight
    seq_unit_tracker #(
        .LATENCY        (DIV_LATENCY)
    ) u_div (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .stall_i        (stall_i),
        .load_i         (div_load),
        .req_i          (req_i),
        .req_latency_i  (req_latency),
        .hazard_o       (div_hazard)
    );

    // Combines tracker status into the issue decision
    issue_control #(
        .MUL_LATENCY      (MUL_LATENCY),
        .DIV_LATENCY      (DIV_LATENCY)
    ) u_issue (
        .stall_i          (stall_i),
        .req_i            (req_i),
        .mul_hazard_i     (mul_hazard),
        .div_hazard_i     (div_hazard),
        .req_latency_o    (req_latency),
        .mul_load_o       (mul_load),
        .div_load_o       (div_load),
        .issue_o          (issue_o),
        .pipeline_empty_o (pipeline_empty_o)
    );

endmodule : scoreboard_top

//--- sim/tb_clock_gen.sv
// Testbench clock and reset

`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin : clock
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2);
            clk_o = ~clk_o;
        end
    end : clock

    // Released just after an edge, like any other driven input
    initial begin : reset
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1;
        rst_n_o = 1'b1;
    end : reset

endmodule : tb_clock_gen

//--- sim/scoreboard_assertions.sv
// Scoreboard protocol assertions

`timescale 1ns/100ps

module scoreboard_assertions (
    input logic                clk_i,
    input logic                rst_n_i,
    input sb_pkg::sb_request_t req_i,
    input logic                issue_i,
    input logic                pipeline_empty_i
);

    // Number of failed assertions
    int unsigned fail_count = 0;

    // No op in flight, so nothing can block, a DIV included
    idle_issue : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pipeline_empty_i |-> issue_i)
        else begin
            fail_count++;
            $error("issue_o low while the pipeline is empty");
        end

    // Counters come out of reset cleared
    empty_after_reset : assert property (@(posedge clk_i)
        $rose(rst_n_i) |=> pipeline_empty_i)
        else begin
            fail_count++;
            $error("pipeline_empty_o low one cycle after reset");
        end

    // Front end holds a blocked request
    hold_blocked_req : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !issue_i |=> $stable(req_i))
        else begin
            fail_count++;
            $error("req_i changed while issue_o was low");
        end

endmodule : scoreboard_assertions

bind scoreboard_top scoreboard_assertions u_assert (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .req_i            (req_i),
    .issue_i          (issue_o),
    .pipeline_empty_i (pipeline_empty_o)
);

//--- sim/scoreboard_tb.sv
// Issue scoreboard testbench

`timescale 1ns/100ps

module scoreboard_tb;

    // One table row, applied for a number of cycles
    typedef struct packed {
        sb_pkg::sb_request_t req;
        logic                stall;
        logic                flush;
        logic                exp_issue;
        logic                exp_empty;
        logic [7:0]          cycles;
    } row_t;

    logic                clk;
    logic                rst_n;
    logic                flush;
    logic                stall;
    sb_pkg::sb_request_t req;
    logic                issue;
    logic                empty;

    row_t table_q [$];
    int   cycle_count = 0;
    int   cycle_limit = 0;

    tb_clock_gen u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    scoreboard_top u_dut (
        .clk_i            (clk),
        .rst_n_i          (rst_n),
        .flush_i          (flush),
        .stall_i          (stall),
        .req_i            (req),
        .issue_o          (issue),
        .pipeline_empty_o (empty)
    );

    // ==============================
    // Helpers
    // ==============================

    task automatic add_row(input sb_pkg::sb_unit_e unit, input int src0, input int src1,
                           input int dest, input int stall_v, input int flush_v,
                           input int exp_issue, input int exp_empty, input int cycles);
        row_t r;
        r.req.unit  = unit;
        r.req.src0  = sb_pkg::reg_addr_t'(src0);
        r.req.src1  = sb_pkg::reg_addr_t'(src1);
        r.req.dest  = sb_pkg::reg_addr_t'(dest);
        r.stall     = (stall_v != 0);
        r.flush     = (flush_v != 0);
        r.exp_issue = (exp_issue != 0);
        r.exp_empty = (exp_empty != 0);
        r.cycles    = 8'(cycles);
        table_q.push_back(r);
        cycle_limit += cycles;
    endtask

    task automatic compare_output(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns: %s = %b, expected %b", $time, name, actual, expected);
            $display(">>> FAIL");
            $fatal(1, "Output mismatch");
        end
    endtask

    // Default latencies, MUL 5 and DIV 36
    // Columns: unit, src0, src1, dest, stall, flush, issue, empty, cycles
    task automatic load_table();
        add_row(sb_pkg::UNIT_NONE, 0, 0, 0, 0, 0, 1, 1, 1);
        add_row(sb_pkg::UNIT_ALU, 1, 2, 4, 0, 0, 1, 1, 3);
        // Reader of x3 waits LATENCY-1 cycles
        add_row(sb_pkg::UNIT_MUL, 1, 2, 3, 0, 0, 1, 1, 1);
        add_row(sb_pkg::UNIT_ALU, 3, 1, 7, 0, 0, 0, 0, 4);
        add_row(sb_pkg::UNIT_ALU, 3, 1, 7, 0, 0, 1, 1, 1);
        // x0 as destination
        add_row(sb_pkg::UNIT_MUL, 1, 2, 0, 0, 0, 1, 1, 1);
        add_row(sb_pkg::UNIT_ALU, 0, 1, 8, 0, 0, 1, 0, 3);
        add_row(sb_pkg::UNIT_NONE, 0, 0, 0, 0, 0, 1, 0, 1);
        add_row(sb_pkg::UNIT_NONE, 0, 0, 0, 0, 0, 1, 1, 1);
        // Back to back MULs
        add_row(sb_pkg::UNIT_MUL, 1, 2, 10, 0, 0, 1, 1, 1);
        add_row(sb_pkg::UNIT_MUL, 1, 2, 11, 0, 0, 1, 0, 1);
        add_row(sb_pkg::UNIT_MUL, 1, 2, 12, 0, 0, 1, 0, 1);
        add_row(sb_pkg::UNIT_MUL, 1, 2, 13, 0, 0, 1, 0, 1);
        add_row(sb_pkg::UNIT_NONE, 0, 0, 0, 0, 0, 1, 0, 4);
        add_row(sb_pkg::UNIT_NONE, 0, 0, 0, 0, 0, 1, 1, 1);
        // ALU ends in the same cycle as a MUL
        add_row(sb_pkg::UNIT_MUL, 1, 2, 14, 0, 0, 1, 1, 1);
        add_row(sb_pkg::UNIT_NONE, 0, 0, 0, 0, 0, 1, 0, 3);
        add_row(sb_pkg::UNIT_ALU, 1, 2, 15, 0, 0, 0, 0, 1);
        add_row(sb_pkg::UNIT_ALU, 1, 2, 15, 0, 0, 1, 1, 1);
        // Second DIV waits, flush frees the divider
        add_row(sb_pkg::UNIT_DIV, 1, 2, 16, 0, 0, 1, 1, 1);
        add_row(sb_pkg::UNIT_DIV, 1, 2, 17, 0, 0, 0, 0, 2);
        add_row(sb_pkg::UNIT_DIV, 1, 2, 17, 0, 1, 0, 0, 1);
        add_row(sb_pkg::UNIT_DIV, 1, 2, 17, 0, 0, 1, 1, 1);
        // Two stalled cycles stretch the MUL shadow
        add_row(sb_pkg::UNIT_MUL, 1, 2, 18, 0, 0, 1, 0, 1);
        add_row(sb_pkg::UNIT_ALU, 18, 1, 19, 0, 0, 0, 0, 1);
        add_row(sb_pkg::UNIT_ALU, 18, 1, 19, 1, 0, 0, 0, 2);
        add_row(sb_pkg::UNIT_ALU, 18, 1, 19, 0, 0, 0, 0, 3);
        add_row(sb_pkg::UNIT_ALU, 18, 1, 19, 0, 0, 1, 0, 1);
        add_row(sb_pkg::UNIT_NONE, 0, 0, 0, 0, 1, 1, 0, 1);
        add_row(sb_pkg::UNIT_NONE, 0, 0, 0, 0, 0, 1, 1, 1);
    endtask

    // ==============================
    // Watchdog
    // ==============================

    always @(negedge clk) begin : watchdog
        cycle_count = cycle_count + 1;
        if (u_dut.u_assert.fail_count != 0) begin
            $display("A bound assertion on the DUT failed");
            $display(">>> FAIL");
            $fatal(1, "Stopped on assertion failure");
        end else if (cycle_count > cycle_limit) begin
            $display("Timeout after %0d cycles, table not finished", cycle_count);
            $display(">>> FAIL");
            $fatal(1, "Stopped on timeout");
        end
    end : watchdog

    // ==============================
    // Stimulus and checks
    // ==============================

    initial begin : run_table
        row_t r;
        req   = '0;
        stall = 1'b0;
        flush = 1'b0;
        load_table();
        cycle_limit = cycle_limit + 20;
        @(posedge rst_n);
        foreach (table_q[k]) begin
            r = table_q[k];
            repeat (r.cycles) begin
                req   = r.req;
                stall = r.stall;
                flush = r.flush;
                // Outputs settled by mid cycle
                @(negedge clk);
                compare_output("issue_o", issue, r.exp_issue);
                compare_output("pipeline_empty_o", empty, r.exp_empty);
                @(posedge clk);
                #1;
            end
        end
        if (u_dut.u_assert.fail_count == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display(">>> FAIL");
            $fatal(1, "Assertion failures");
        end
    end : run_table

endmodule : scoreboard_tb

//--- list.f
source/sb_pkg.sv
source/pipe_unit_tracker.sv
source/seq_unit_tracker.sv
source/issue_control.sv
source/scoreboard_top.sv
sim/tb_clock_gen.sv
sim/scoreboard_assertions.sv
sim/scoreboard_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = scoreboard_tb
FILELIST  = list.f
OBJ_DIR   = obj_dir
LOG       = sim.log
SIM_ARGS  = +verilator+error+limit+100
FAIL_MSG  = >>> FAIL
PASS_MSG  = >>> PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -qF '$(PASS_MSG)' $(LOG) || { echo "Simulation did not complete"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
